// ==== flist.f ====
fetch_pkg.sv
axi_pkg.sv
fetch_ctrl.sv
fetch_credit.sv
fetch_buffer.sv
fetch_top.sv
tb_axi_imem.sv
tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - axi_pkg.sv
  - fetch_ctrl.sv
  - fetch_credit.sv
  - fetch_buffer.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_axi_imem.sv
      - tb_fetch.sv

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

    localparam logic [31:0] SEED       = 32'h07b0_b2db;
    localparam logic [31:0] MEM_KEY    = 32'h5a5a_5a5a;
    localparam logic [31:0] FAULT_BASE = 32'h1c00_0400;
    localparam int          RUN_CYCLES = 4000;
    localparam int          WAIT_LIMIT = 100;

    logic                          clk;
    logic                          rstn;
    logic                          flush;
    logic [fetch_pkg::XLEN-1:0]    redirect_pc;
    logic [fetch_pkg::PLV_W-1:0]   plv;
    logic                          take0;
    logic                          take1;
    logic [axi_pkg::ADDR_W-1:0]    araddr;
    logic [axi_pkg::PROT_W-1:0]    arprot;
    logic                          arvalid;
    logic                          arready;
    logic [axi_pkg::DATA_W-1:0]    rdata;
    logic [axi_pkg::RESP_W-1:0]    rresp;
    logic                          rvalid;
    logic                          rready;
    logic [fetch_pkg::XLEN-1:0]    ir0;
    logic [fetch_pkg::XLEN-1:0]    ir1;
    logic [fetch_pkg::XLEN-1:0]    pc0;
    logic [fetch_pkg::XLEN-1:0]    pc1;
    logic [fetch_pkg::PLV_W-1:0]   plv0;
    logic [fetch_pkg::PLV_W-1:0]   plv1;
    logic                          fault0;
    logic                          fault1;
    logic                          valid0;
    logic                          valid1;

    int                            errors;
    int                            timeouts;
    int                            cycle;
    int                            stall_left;
    logic [31:0]                   lfsr;
    logic [31:0]                   r;

    // Reference model state
    int                            held;         // Instructions queued
    logic                          txn_open;     // Read raised and not yet answered
    logic                          txn_live;     // No flush since that read was raised
    logic [31:0]                   fetch_pc;
    logic [31:0]                   exp_pc;       // PC of the next instruction taken
    logic                          after_flush;
    logic [fetch_pkg::PLV_W-1:0]   flush_plv;

    fetch_top DUT (.*);

    tb_axi_imem #(.SEED(SEED)) u_mem (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        errors++;
        $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    task automatic wait_for_fetch();
        int n;
        n     = 0;
        take0 = 1'b0;
        take1 = 1'b0;
        while (!valid0 && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!valid0)
        begin
            timeouts++;
            $display("Timeout: no instruction reached decode within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Targets span both sides of the fault boundary, odd words included
    task automatic do_flush();
        logic [31:0] v;
        draw_bits(9, v);
        redirect_pc = fetch_pkg::RESET_PC + {21'b0, v[8:0], 2'b00};
        draw_bits(2, v);
        plv   = v[1:0];
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        wait_for_fetch();
    endtask

    task automatic finish_run();
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    endtask

    always @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            held        = 0;
            txn_open    = 1'b0;
            txn_live    = 1'b0;
            fetch_pc    = fetch_pkg::RESET_PC;
            exp_pc      = fetch_pkg::RESET_PC;
            after_flush = 1'b0;
            flush_plv   = plv;
        end
        else
        begin
            if (arvalid && !txn_open)
            begin
                txn_open = 1'b1;    // First cycle of a new read
                txn_live = 1'b1;
            end
            if (flush)
                txn_live = 1'b0;
            if (rvalid && rready)
            begin
                if (txn_live)
                begin
                    held     = held + (fetch_pc[2] ? 1 : 2);
                    fetch_pc = {fetch_pc[31:3], 3'b000} + 32'd8;
                end
                txn_open = 1'b0;
            end
            held = held - int'(take0) - int'(take1);
            if (flush)
            begin
                held        = 0;
                fetch_pc    = redirect_pc;
                exp_pc      = redirect_pc;
                after_flush = 1'b1;
                flush_plv   = plv;
            end
            else if (take0)
            begin
                exp_pc      = exp_pc + (take1 ? 32'd8 : 32'd4);
                after_flush = 1'b0;
            end
        end
    end

    ir_slot0: assert property (@(posedge clk) disable iff (!rstn)
        valid0 && !fault0 |-> ir0 == (pc0 ^ MEM_KEY))
        else flag_mismatch("ir0", $sampled(ir0), $sampled(pc0) ^ MEM_KEY);

    ir_slot1: assert property (@(posedge clk) disable iff (!rstn)
        valid1 && !fault1 |-> ir1 == (pc1 ^ MEM_KEY))
        else flag_mismatch("ir1", $sampled(ir1), $sampled(pc1) ^ MEM_KEY);

    pc_step0: assert property (@(posedge clk) disable iff (!rstn)
        take0 && !after_flush |-> pc0 == exp_pc)
        else flag_mismatch("pc0", $sampled(pc0), $sampled(exp_pc));

    pc_step1: assert property (@(posedge clk) disable iff (!rstn)
        take1 |-> pc1 == exp_pc + 4)
        else flag_mismatch("pc1", $sampled(pc1), $sampled(exp_pc) + 4);

    // First take after a redirect, odd-word targets included
    pc_redirect: assert property (@(posedge clk) disable iff (!rstn)
        take0 && after_flush |-> pc0 == exp_pc)
        else flag_mismatch("pc0", $sampled(pc0), $sampled(exp_pc));

    plv_slot0: assert property (@(posedge clk) disable iff (!rstn)
        take0 |-> plv0 == flush_plv)
        else flag_mismatch("plv0", $sampled(plv0), $sampled(flush_plv));

    plv_slot1: assert property (@(posedge clk) disable iff (!rstn)
        take1 |-> plv1 == flush_plv)
        else flag_mismatch("plv1", $sampled(plv1), $sampled(flush_plv));

    fault_slot0: assert property (@(posedge clk) disable iff (!rstn)
        valid0 |-> fault0 == (pc0 >= FAULT_BASE))
        else flag_mismatch("fault0", $sampled(fault0), $sampled(pc0) >= FAULT_BASE);

    fault_slot1: assert property (@(posedge clk) disable iff (!rstn)
        valid1 |-> fault1 == (pc1 >= FAULT_BASE))
        else flag_mismatch("fault1", $sampled(fault1), $sampled(pc1) >= FAULT_BASE);

    queue_level0: assert property (@(posedge clk) disable iff (!rstn)
        valid0 == (held != 0))
        else flag_mismatch("valid0", $sampled(valid0), $sampled(held) != 0);

    queue_level1: assert property (@(posedge clk) disable iff (!rstn)
        valid1 == (held > 1))
        else flag_mismatch("valid1", $sampled(valid1), $sampled(held) > 1);

    issue_stop: assert property (@(posedge clk) disable iff (!rstn)
        arvalid |-> held + 2 <= fetch_pkg::FB_DEPTH)
        else report_failure("read requested with no room left for a pair in the queue");

    // A read raised since the last flush carries that flush's privilege level
    arprot_plv: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && (txn_live || !txn_open) |-> arprot[0] == flush_plv[0])
        else flag_mismatch("arprot[0]", $sampled(arprot[0]), $sampled(flush_plv[0]));

    // Ready for data only between the AR handshake and the response
    read_ready: assert property (@(posedge clk) disable iff (!rstn)
        rready == (txn_open && !arvalid))
        else flag_mismatch("rready", $sampled(rready), $sampled(txn_open && !arvalid));

    flush_clear: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !valid0)
        else flag_mismatch("valid0", $sampled(valid0), 0);

    initial
    begin
        clk         = 1'b0;
        plv         = '0;
        rstn        = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        take0       = 1'b0;
        take1       = 1'b0;
        errors      = 0;
        timeouts    = 0;
        stall_left  = 0;
        lfsr        = SEED;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_for_fetch();
        for (cycle = 0; cycle < RUN_CYCLES; cycle++)
        begin
            @(posedge clk);
            #1;
            take0 = 1'b0;
            take1 = 1'b0;
            if (stall_left > 0)
                stall_left--;
            else
            begin
                draw_bits(8, r);
                if (r < 3)
                    do_flush();
                else if (r < 11)
                begin
                    draw_bits(4, r);
                    stall_left = 20 + r;    // Long enough for the queue to fill
                end
                else
                begin
                    take0 = valid0 && (r[1:0] != 2'b00);
                    take1 = take0 && valid1 && r[2];
                end
            end
        end
        finish_run();
    end

endmodule

// ==== tb_axi_imem.sv ====
`timescale 1ns/1ps

module tb_axi_imem #(
    parameter logic [31:0] SEED = 32'h07b0_b2db
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [axi_pkg::ADDR_W-1:0]    araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [axi_pkg::DATA_W-1:0]    rdata,
    output logic [axi_pkg::RESP_W-1:0]    rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    localparam logic [axi_pkg::ADDR_W-1:0] FAULT_BASE = 32'h1c00_0400;

    logic [31:0]                 lfsr;
    logic [axi_pkg::ADDR_W-1:0]  req_addr;
    logic [axi_pkg::ADDR_W-1:0]  addr_seen;
    logic [1:0]                  ar_wait;
    logic [1:0]                  r_wait;
    logic                        r_pend;     // Read accepted, data not yet offered
    logic                        ar_fire;
    logic                        r_fire;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Contents follow from the byte address of each word
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ 32'h5a5a_5a5a;
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        int i;
        for (i = 0; i < 2; i++)
        begin
            lfsr = lfsr_next(lfsr);
            d[i] = lfsr[0];
        end
    endtask

    initial
    begin
        lfsr    = SEED;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = axi_pkg::RESP_OKAY;
        r_pend  = 1'b0;
        r_wait  = '0;
        draw_delay(ar_wait);
    end

    always @(posedge clk)
    begin
        ar_fire   = arvalid && arready;     // Handshakes completing at this edge
        r_fire    = rvalid && rready;
        addr_seen = araddr;
        #1;
        if (!rstn)
        begin
            arready = 1'b0;
            rvalid  = 1'b0;
            r_pend  = 1'b0;
        end
        else
        begin
            if (r_fire)
                rvalid = 1'b0;
            if (ar_fire)
            begin
                arready  = 1'b0;
                req_addr = addr_seen;
                r_pend   = 1'b1;
                draw_delay(r_wait);
                draw_delay(ar_wait);
            end
            else if (arvalid && !arready)
            begin
                if (ar_wait == 0)
                    arready = 1'b1;
                else
                    ar_wait = ar_wait - 1'b1;
            end
            if (r_pend)
            begin
                if (r_wait == 0)
                begin
                    rvalid = 1'b1;
                    r_pend = 1'b0;
                    rdata  = {word_at(req_addr + 4), word_at(req_addr)};
                    rresp  = (req_addr >= FAULT_BASE) ? axi_pkg::RESP_SLVERR
                                                      : axi_pkg::RESP_OKAY;
                end
                else
                    r_wait = r_wait - 1'b1;
            end
        end
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          flush,
    input  logic [fetch_pkg::XLEN-1:0]    redirect_pc,
    input  logic [fetch_pkg::PLV_W-1:0]   plv,
    input  logic                          take0,
    input  logic                          take1,
    output logic [axi_pkg::ADDR_W-1:0]    araddr,
    output logic [axi_pkg::PROT_W-1:0]    arprot,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [axi_pkg::DATA_W-1:0]    rdata,
    input  logic [axi_pkg::RESP_W-1:0]    rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [fetch_pkg::XLEN-1:0]    ir0,
    output logic [fetch_pkg::XLEN-1:0]    ir1,
    output logic [fetch_pkg::XLEN-1:0]    pc0,
    output logic [fetch_pkg::XLEN-1:0]    pc1,
    output logic [fetch_pkg::PLV_W-1:0]   plv0,
    output logic [fetch_pkg::PLV_W-1:0]   plv1,
    output logic                          fault0,
    output logic                          fault1,
    output logic                          valid0,
    output logic                          valid1
);

    logic                         reserve;
    logic                         can_issue;
    logic                         push;
    logic                         push_two;
    logic [fetch_pkg::XLEN-1:0]   push_pc;
    logic [axi_pkg::DATA_W-1:0]   push_data;
    logic [fetch_pkg::PLV_W-1:0]  push_plv;
    logic                         push_fault;
    logic [1:0]                   pop_cnt;

    fetch_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .plv         (plv),
        .can_issue   (can_issue),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .araddr      (araddr),
        .arprot      (arprot),
        .arvalid     (arvalid),
        .rready      (rready),
        .reserve     (reserve),
        .push        (push),
        .push_two    (push_two),
        .push_pc     (push_pc),
        .push_data   (push_data),
        .push_plv    (push_plv),
        .push_fault  (push_fault)
    );

    fetch_credit u_credit (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .reserve   (reserve),
        .push      (push),
        .push_two  (push_two),
        .pop_cnt   (pop_cnt),
        .can_issue (can_issue)
    );

    fetch_buffer u_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push       (push),
        .push_two   (push_two),
        .push_pc    (push_pc),
        .push_data  (push_data),
        .push_plv   (push_plv),
        .push_fault (push_fault),
        .take0      (take0),
        .take1      (take1),
        .ir0        (ir0),
        .ir1        (ir1),
        .pc0        (pc0),
        .pc1        (pc1),
        .plv0       (plv0),
        .plv1       (plv1),
        .fault0     (fault0),
        .fault1     (fault1),
        .valid0     (valid0),
        .valid1     (valid1),
        .pop_cnt    (pop_cnt)
    );

endmodule

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          flush,
    input  logic                          push,
    input  logic                          push_two,
    input  logic [fetch_pkg::XLEN-1:0]    push_pc,
    input  logic [axi_pkg::DATA_W-1:0]    push_data,
    input  logic [fetch_pkg::PLV_W-1:0]   push_plv,
    input  logic                          push_fault,
    input  logic                          take0,
    input  logic                          take1,
    output logic [fetch_pkg::XLEN-1:0]    ir0,
    output logic [fetch_pkg::XLEN-1:0]    ir1,
    output logic [fetch_pkg::XLEN-1:0]    pc0,
    output logic [fetch_pkg::XLEN-1:0]    pc1,
    output logic [fetch_pkg::PLV_W-1:0]   plv0,
    output logic [fetch_pkg::PLV_W-1:0]   plv1,
    output logic                          fault0,
    output logic                          fault1,
    output logic                          valid0,
    output logic                          valid1,
    output logic [1:0]                    pop_cnt
);

    logic [fetch_pkg::XLEN-1:0]  ir_q  [fetch_pkg::FB_DEPTH];
    logic [fetch_pkg::XLEN-1:0]  pc_q  [fetch_pkg::FB_DEPTH];
    logic [fetch_pkg::PLV_W-1:0] plv_q [fetch_pkg::FB_DEPTH];
    logic [fetch_pkg::FB_DEPTH-1:0] fault_q;

    logic [fetch_pkg::FB_PTR_W-1:0] head;
    logic [fetch_pkg::FB_PTR_W-1:0] tail;
    logic [fetch_pkg::FB_PTR_W-1:0] head_1;
    logic [fetch_pkg::FB_PTR_W-1:0] tail_1;
    logic [fetch_pkg::FB_CNT_W-1:0] count;
    logic [1:0]                     push_cnt;

    assign head_1   = head + 1'b1;
    assign tail_1   = tail + 1'b1;
    assign push_cnt = push ? {push_two, !push_two} : 2'b00;
    assign pop_cnt  = {take1, take0 && !take1};

    // Two oldest entries face decode
    assign ir0    = ir_q[head];
    assign ir1    = ir_q[head_1];
    assign pc0    = pc_q[head];
    assign pc1    = pc_q[head_1];
    assign plv0   = plv_q[head];
    assign plv1   = plv_q[head_1];
    assign fault0 = fault_q[head];
    assign fault1 = fault_q[head_1];
    assign valid0 = (count != 0);
    assign valid1 = (count > 1);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            head  <= head + pop_cnt;
            tail  <= tail + push_cnt;
            count <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            pc_q[tail]    <= push_pc;
            plv_q[tail]   <= push_plv;
            fault_q[tail] <= push_fault;
            if (push_two)
            begin
                ir_q[tail]      <= push_data[fetch_pkg::XLEN-1:0];
                ir_q[tail_1]    <= push_data[2*fetch_pkg::XLEN-1:fetch_pkg::XLEN];
                pc_q[tail_1]    <= push_pc + 4;
                plv_q[tail_1]   <= push_plv;
                fault_q[tail_1] <= push_fault;
            end
            else
                ir_q[tail] <= push_data[2*fetch_pkg::XLEN-1:fetch_pkg::XLEN];  // Upper word only
        end
    end

    // Credit in fetch_credit must keep this from firing
    no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        push |-> count + push_cnt <= fetch_pkg::FB_DEPTH + pop_cnt);

    take_order: assert property (@(posedge clk) disable iff (!rstn)
        take1 |-> take0);

    take_valid: assert property (@(posedge clk) disable iff (!rstn)
        (!take0 || valid0) && (!take1 || valid1));

endmodule

// ==== fetch_credit.sv ====
`timescale 1ns/1ps

module fetch_credit (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        reserve,
    input  logic        push,
    input  logic        push_two,
    input  logic [1:0]  pop_cnt,
    output logic        can_issue
);

    logic [fetch_pkg::FB_CNT_W-1:0] credit;
    logic [fetch_pkg::FB_CNT_W-1:0] credit_nxt;
    logic                           refund;

    // Response returns the pair reservation, minus what was really pushed
    assign refund = push && !push_two;

    always_comb
    begin
        if (flush)
            credit_nxt = fetch_pkg::FB_DEPTH;
        else
            credit_nxt = credit + pop_cnt + refund - (reserve ? 2'd2 : 2'd0);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            credit    <= fetch_pkg::FB_DEPTH;
            can_issue <= 1'b1;
        end
        else
        begin
            credit    <= credit_nxt;
            can_issue <= (credit_nxt >= 2);   // Room for a full pair
        end
    end

    // Underflow wraps above FB_DEPTH, so this bound catches both directions
    credit_range: assert property (@(posedge clk) disable iff (!rstn)
        credit <= fetch_pkg::FB_DEPTH);

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          flush,
    input  logic [fetch_pkg::XLEN-1:0]    redirect_pc,
    input  logic [fetch_pkg::PLV_W-1:0]   plv,
    input  logic                          can_issue,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [axi_pkg::DATA_W-1:0]    rdata,
    input  logic [axi_pkg::RESP_W-1:0]    rresp,
    output logic [axi_pkg::ADDR_W-1:0]    araddr,
    output logic [axi_pkg::PROT_W-1:0]    arprot,
    output logic                          arvalid,
    output logic                          rready,
    output logic                          reserve,
    output logic                          push,
    output logic                          push_two,
    output logic [fetch_pkg::XLEN-1:0]    push_pc,
    output logic [axi_pkg::DATA_W-1:0]    push_data,
    output logic [fetch_pkg::PLV_W-1:0]   push_plv,
    output logic                          push_fault
);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, DRAIN} state_t;

    state_t state;
    state_t state_nxt;
    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] pc_nxt;
    logic stale;        // AR still pending when a flush came
    logic ar_hs;

    assign arvalid = (state == ADDR);
    assign rready  = (state == DATA) || (state == DRAIN);
    assign ar_hs   = arvalid && arready;

    // A request made stale by a flush never holds a reservation
    assign reserve = ar_hs && !stale && !flush;

    assign push       = (state == DATA) && rvalid && !flush;
    assign push_two   = !pc[2];     // Odd-word target gives only the upper word
    assign push_pc    = pc;
    assign push_data  = rdata;
    assign push_plv   = plv;
    assign push_fault = (rresp == axi_pkg::RESP_SLVERR);

    always_comb
    begin
        if (flush)
            pc_nxt = redirect_pc;
        else if (push)
            pc_nxt = {pc[fetch_pkg::XLEN-1:3], 3'b000} + fetch_pkg::PAIR_BYTES;
        else
            pc_nxt = pc;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
                if (flush || can_issue)
                    state_nxt = ADDR;
            ADDR:
                if (arready)
                    state_nxt = (flush || stale) ? DRAIN : DATA;
            DATA:
                if (rvalid)
                    state_nxt = flush ? ADDR : IDLE;
                else if (flush)
                    state_nxt = DRAIN;
            DRAIN:
                if (rvalid)
                    state_nxt = ADDR;   // Credit is full again after the flush
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= IDLE;
            pc    <= fetch_pkg::RESET_PC;
            stale <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            pc    <= pc_nxt;
            if (flush && arvalid && !arready)
                stale <= 1'b1;
            else if (ar_hs)
                stale <= 1'b0;
        end
    end

    // Captured on entry to ADDR, held until the handshake
    always_ff @(posedge clk)
    begin
        if (state_nxt == ADDR && state != ADDR)
        begin
            araddr <= {pc_nxt[fetch_pkg::XLEN-1:3], 3'b000};
            arprot <= {1'b1, 1'b0, plv[0]};     // Instruction access
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot));

endmodule

// ==== axi_pkg.sv ====
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int PROT_W = 3;
    localparam int RESP_W = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // Instruction and PC width
    localparam int XLEN = 32;

    // Privilege level field
    localparam int PLV_W = 2;

    // Queue sizing
    localparam int FB_CNT_W = 4;                    // Holds 0..FB_DEPTH
    localparam int FB_PTR_W = 3;                    // Index into the queue, wraps
    localparam logic [FB_CNT_W-1:0] FB_DEPTH = 8;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // One read returns an aligned instruction pair
    localparam logic [XLEN-1:0] PAIR_BYTES = 8;

endpackage
